// File: hw/ipv4_fwd_pkg.sv
/* IPv4 forwarding definitions */

package ipv4_fwd_pkg;

    ////////////////////////////////////////
    // Stream format

    localparam int data_bytes = 8;

    typedef logic [data_bytes*8-1:0] data_t;
    typedef logic [data_bytes-1:0]   keep_t;

    // Beat index within a frame, holds at 7
    typedef logic [2:0] beat_idx_t;

    // Input beat to output beat
    localparam int pipe_latency = 5;

    ////////////////////////////////////////
    // Header layout and constants

    localparam int eth_hdr_bytes  = 14;
    localparam int ipv4_hdr_bytes = 20;

    localparam logic [15:0] ipv4_ether_type = 16'h0800;
    localparam logic [3:0]  ipv4_version    = 4'd4;
    localparam logic [3:0]  ipv4_ihl        = 4'd5;

    // Byte 0 of the frame sits in lane 0, the top byte of beat 0
    localparam int ether_type_beat = (eth_hdr_bytes - 2) / data_bytes;
    localparam int ether_type_lane = (eth_hdr_bytes - 2) % data_bytes;
    localparam int ver_ihl_beat    = eth_hdr_bytes / data_bytes;
    localparam int ver_ihl_lane    = eth_hdr_bytes % data_bytes;

    localparam int ttl_beat = 2;
    localparam int ttl_lane = 6;
    localparam int chk_beat = 3;
    localparam int chk_lane = 0;

    localparam int hdr_last_beat = (eth_hdr_bytes + ipv4_hdr_bytes - 1) / data_bytes;

    ////////////////////////////////////////
    // Forwarding verdict

    typedef enum logic [1:0] {
        fwd_ok,
        fwd_not_ipv4,
        fwd_bad_chk,
        fwd_ttl_expired
    } fwd_verdict_e;

endpackage

// File: hw/ipv4_fwd_ifcs.sv
/* Internal stage interfaces */

`timescale 1ns/1ps

// Header fields, decode to execute
interface hdr_fields_ifc;
    logic        fields_valid;
    logic [15:0] ether_type;
    logic [3:0]  version;
    logic [3:0]  ihl;
    logic [7:0]  ttl;
    logic [15:0] hdr_chk;
    // Folded ones' complement sum over all ten header words
    logic [15:0] hdr_sum;

    modport decode_mp (output fields_valid, ether_type, version, ihl, ttl, hdr_chk, hdr_sum);
    modport execute_mp (input fields_valid, ether_type, version, ihl, ttl, hdr_chk, hdr_sum);
endinterface

// Verdict and rewrite values, execute to result
interface fwd_verdict_ifc;
    logic                       verdict_valid;
    ipv4_fwd_pkg::fwd_verdict_e verdict;
    logic [7:0]                 new_ttl;
    logic [15:0]                new_chk;

    modport execute_mp (output verdict_valid, verdict, new_ttl, new_chk);
    modport result_mp (input verdict_valid, verdict, new_ttl, new_chk);
endinterface

// File: hw/ipv4_hdr_decode.sv
/* IPv4 header decode */

`timescale 1ns/1ps

module ipv4_hdr_decode (
    input  logic                core_clk_ifc,
    input  logic                rst_n,
    input  logic                in_valid,
    input  ipv4_fwd_pkg::data_t in_data,
    input  logic                in_last,
    hdr_fields_ifc.decode_mp    fields
);

    localparam int dw = ipv4_fwd_pkg::data_bytes * 8;
    localparam int hdr_start = ipv4_fwd_pkg::eth_hdr_bytes;
    localparam int hdr_end = ipv4_fwd_pkg::eth_hdr_bytes + ipv4_fwd_pkg::ipv4_hdr_bytes;

    ipv4_fwd_pkg::beat_idx_t beat_idx;
    logic [19:0]             sum_q;
    logic [19:0]             beat_words;
    logic [19:0]             sum_next;
    logic [16:0]             fold_1;
    logic [15:0]             fold_2;

    ////////////////////////////////////////
    // Beat counter

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            beat_idx            <= '0;
            fields.fields_valid <= 1'b0;
        end else begin
            fields.fields_valid <= in_valid && (beat_idx == ipv4_fwd_pkg::hdr_last_beat);
            if (in_valid) begin
                if (in_last) begin
                    beat_idx <= '0;
                end else if (beat_idx != '1) begin
                    beat_idx <= beat_idx + 3'd1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Header checksum accumulation

    // Add every 16-bit half of the beat that falls inside the IPv4 header
    always_comb begin
        int byte_off;
        beat_words = '0;
        for (int h = 0; h < ipv4_fwd_pkg::data_bytes / 2; h++) begin
            byte_off = int'(beat_idx) * ipv4_fwd_pkg::data_bytes + 2 * h;
            if (byte_off >= hdr_start && byte_off < hdr_end) begin
                beat_words = beat_words + {4'd0, in_data[dw-1-16*h -: 16]};
            end
        end
    end

    // Beat 0 holds no header bytes, so it restarts the sum
    assign sum_next = ((beat_idx == '0) ? 20'd0 : sum_q) + beat_words;

    // End-around carry, twice is enough for ten words
    assign fold_1 = {1'b0, sum_next[15:0]} + {13'd0, sum_next[19:16]};
    assign fold_2 = fold_1[15:0] + {15'd0, fold_1[16]};

    ////////////////////////////////////////
    // Field capture

    always_ff @(posedge core_clk_ifc) begin
        if (in_valid) begin
            sum_q <= sum_next;
            if (beat_idx == ipv4_fwd_pkg::ether_type_beat) begin
                fields.ether_type <= in_data[dw-1-8*ipv4_fwd_pkg::ether_type_lane -: 16];
            end
            if (beat_idx == ipv4_fwd_pkg::ver_ihl_beat) begin
                {fields.version, fields.ihl} <= in_data[dw-1-8*ipv4_fwd_pkg::ver_ihl_lane -: 8];
            end
            if (beat_idx == ipv4_fwd_pkg::ttl_beat) begin
                fields.ttl <= in_data[dw-1-8*ipv4_fwd_pkg::ttl_lane -: 8];
            end
            if (beat_idx == ipv4_fwd_pkg::chk_beat) begin
                fields.hdr_chk <= in_data[dw-1-8*ipv4_fwd_pkg::chk_lane -: 16];
            end
            if (beat_idx == ipv4_fwd_pkg::hdr_last_beat) begin
                fields.hdr_sum <= fold_2;
            end
        end
    end

endmodule

// File: hw/ipv4_ttl_execute.sv
/* Forwarding verdict and TTL update */

`timescale 1ns/1ps

module ipv4_ttl_execute (
    input  logic               core_clk_ifc,
    input  logic               rst_n,
    hdr_fields_ifc.execute_mp  fields,
    fwd_verdict_ifc.execute_mp verdict
);

    ipv4_fwd_pkg::fwd_verdict_e verdict_next;
    logic [7:0]                 ttl_dec;
    logic [17:0]                upd_sum;
    logic [16:0]                upd_fold;
    logic [15:0]                upd_chk;

    ////////////////////////////////////////
    // Verdict, in priority order

    always_comb begin
        if (fields.ether_type != ipv4_fwd_pkg::ipv4_ether_type ||
            fields.version != ipv4_fwd_pkg::ipv4_version ||
            fields.ihl != ipv4_fwd_pkg::ipv4_ihl) begin
            verdict_next = ipv4_fwd_pkg::fwd_not_ipv4;
        end else if (fields.hdr_sum != 16'hffff) begin
            verdict_next = ipv4_fwd_pkg::fwd_bad_chk;
        end else if (fields.ttl <= 8'd1) begin
            verdict_next = ipv4_fwd_pkg::fwd_ttl_expired;
        end else begin
            verdict_next = ipv4_fwd_pkg::fwd_ok;
        end
    end

    ////////////////////////////////////////
    // Incremental checksum

    assign ttl_dec = fields.ttl - 8'd1;

    // HC' = ~(~HC + ~m + m') with m the TTL/protocol word.
    // Protocol is unchanged, so it cancels and zero stands in for it
    assign upd_sum = {2'b00, ~fields.hdr_chk}
                   + {2'b00, ~{fields.ttl, 8'h00}}
                   + {2'b00, ttl_dec, 8'h00};

    assign upd_fold = {1'b0, upd_sum[15:0]} + {15'd0, upd_sum[17:16]};
    assign upd_chk  = ~(upd_fold[15:0] + {15'd0, upd_fold[16]});

    ////////////////////////////////////////
    // Outputs

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            verdict.verdict_valid <= 1'b0;
        end else begin
            verdict.verdict_valid <= fields.fields_valid;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (fields.fields_valid) begin
            verdict.verdict <= verdict_next;
            verdict.new_ttl <= ttl_dec;
            verdict.new_chk <= upd_chk;
        end
    end

endmodule

// File: hw/ipv4_result_stage.sv
/* Delay line and header rewrite */

`timescale 1ns/1ps

module ipv4_result_stage #(
    parameter int delay_depth = ipv4_fwd_pkg::pipe_latency
) (
    input  logic                core_clk_ifc,
    input  logic                rst_n,
    input  logic                in_valid,
    input  ipv4_fwd_pkg::data_t in_data,
    input  ipv4_fwd_pkg::keep_t in_keep,
    input  logic                in_last,
    fwd_verdict_ifc.result_mp   verdict,
    output logic                out_valid,
    output ipv4_fwd_pkg::data_t out_data,
    output ipv4_fwd_pkg::keep_t out_keep,
    output logic                out_last,
    output logic                out_hdr_err
);

    localparam int dw = ipv4_fwd_pkg::data_bytes * 8;

    logic                       valid_q [delay_depth];
    logic                       last_q  [delay_depth];
    ipv4_fwd_pkg::keep_t        keep_q  [delay_depth];
    ipv4_fwd_pkg::data_t        data_q  [delay_depth];
    ipv4_fwd_pkg::beat_idx_t    out_beat_idx;
    ipv4_fwd_pkg::fwd_verdict_e verdict_q;
    ipv4_fwd_pkg::fwd_verdict_e cur_verdict;
    logic [7:0]                 new_ttl_q;
    logic [15:0]                new_chk_q;
    logic [7:0]                 cur_new_ttl;
    logic [15:0]                cur_new_chk;

    ////////////////////////////////////////
    // Delay line

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            for (int i = 0; i < delay_depth; i++) begin
                valid_q[i] <= 1'b0;
                last_q[i]  <= 1'b0;
            end
            verdict_q    <= ipv4_fwd_pkg::fwd_ok;
            out_beat_idx <= '0;
        end else begin
            valid_q[0] <= in_valid;
            last_q[0]  <= in_valid && in_last;
            for (int i = 1; i < delay_depth; i++) begin
                valid_q[i] <= valid_q[i-1];
                last_q[i]  <= last_q[i-1];
            end
            if (verdict.verdict_valid) begin
                verdict_q <= verdict.verdict;
            end
            // Outgoing beat position
            if (out_valid) begin
                if (out_last) begin
                    out_beat_idx <= '0;
                end else if (out_beat_idx != '1) begin
                    out_beat_idx <= out_beat_idx + 3'd1;
                end
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        data_q[0] <= in_data;
        keep_q[0] <= in_keep;
        for (int i = 1; i < delay_depth; i++) begin
            data_q[i] <= data_q[i-1];
            keep_q[i] <= keep_q[i-1];
        end
        if (verdict.verdict_valid) begin
            new_ttl_q <= verdict.new_ttl;
            new_chk_q <= verdict.new_chk;
        end
    end

    ////////////////////////////////////////
    // Rewrite and flag

    // A verdict arriving this cycle is used at once, for short delay lines
    assign cur_verdict = verdict.verdict_valid ? verdict.verdict : verdict_q;
    assign cur_new_ttl = verdict.verdict_valid ? verdict.new_ttl : new_ttl_q;
    assign cur_new_chk = verdict.verdict_valid ? verdict.new_chk : new_chk_q;

    always_comb begin
        out_data = data_q[delay_depth-1];
        if (cur_verdict == ipv4_fwd_pkg::fwd_ok) begin
            if (out_beat_idx == ipv4_fwd_pkg::ttl_beat) begin
                out_data[dw-1-8*ipv4_fwd_pkg::ttl_lane -: 8] = cur_new_ttl;
            end
            if (out_beat_idx == ipv4_fwd_pkg::chk_beat) begin
                out_data[dw-1-8*ipv4_fwd_pkg::chk_lane -: 16] = cur_new_chk;
            end
        end
    end

    assign out_valid   = valid_q[delay_depth-1];
    assign out_last    = last_q[delay_depth-1];
    assign out_keep    = keep_q[delay_depth-1];
    assign out_hdr_err = out_valid && out_last && (cur_verdict != ipv4_fwd_pkg::fwd_ok);

endmodule

// File: hw/ipv4_forwarder.sv
/* IPv4 forwarding stage */

`timescale 1ns/1ps

module ipv4_forwarder #(
    parameter int latency = ipv4_fwd_pkg::pipe_latency
) (
    input  logic                core_clk_ifc,
    input  logic                rst_n,
    input  logic                in_valid,
    input  ipv4_fwd_pkg::data_t in_data,
    input  ipv4_fwd_pkg::keep_t in_keep,
    input  logic                in_last,
    output logic                out_valid,
    output ipv4_fwd_pkg::data_t out_data,
    output ipv4_fwd_pkg::keep_t out_keep,
    output logic                out_last,
    output logic                out_hdr_err
);

    hdr_fields_ifc  fields_bus ();
    fwd_verdict_ifc verdict_bus ();

    ////////////////////////////////////////
    // Decode, execute, result

    ipv4_hdr_decode u_decode (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .in_last      (in_last),
        .fields       (fields_bus)
    );

    ipv4_ttl_execute u_execute (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .fields       (fields_bus),
        .verdict      (verdict_bus)
    );

    // Whole frame passes through here, decode only taps it
    ipv4_result_stage #(
        .delay_depth (latency)
    ) u_result (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .in_keep      (in_keep),
        .in_last      (in_last),
        .verdict      (verdict_bus),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_keep     (out_keep),
        .out_last     (out_last),
        .out_hdr_err  (out_hdr_err)
    );

endmodule

// File: testbench/ipv4_forwarder_props.sv
/* Stream timing assertions */

`timescale 1ns/1ps

module ipv4_forwarder_props #(
    parameter int latency = ipv4_fwd_pkg::pipe_latency
) (
    input logic core_clk_ifc,
    input logic rst_n,
    input logic in_valid,
    input logic out_valid,
    input logic out_last,
    input logic out_hdr_err
);

    int fail_count = 0;

    // Every input beat leaves exactly latency cycles later
    valid_delay: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        out_valid == $past(in_valid, latency))
    else begin
        $error("out_valid does not follow in_valid by %0d cycles", latency);
        fail_count++;
    end

    err_on_last: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        out_hdr_err |-> out_last)
    else begin
        $error("out_hdr_err high without out_last");
        fail_count++;
    end

    // Outputs held low while in reset
    reset_quiet: assert property (@(posedge core_clk_ifc)
        !rst_n |=> (!out_valid && !out_last && !out_hdr_err))
    else begin
        $error("outputs active during reset");
        fail_count++;
    end

endmodule

// File: testbench/ipv4_forwarder_checker.sv
/* Output prediction and compare */

`timescale 1ns/1ps

module ipv4_forwarder_checker #(
    parameter int latency = ipv4_fwd_pkg::pipe_latency
) (
    input logic                core_clk_ifc,
    input logic                rst_n,
    input logic                in_valid,
    input logic                in_last,
    input ipv4_fwd_pkg::data_t in_data,
    input ipv4_fwd_pkg::keep_t in_keep,
    input logic                exp_err,
    input logic                out_valid,
    input logic                out_last,
    input ipv4_fwd_pkg::data_t out_data,
    input ipv4_fwd_pkg::keep_t out_keep,
    input logic                out_hdr_err
);

    int                  error_count = 0;
    int                  frames_done = 0;
    longint              cycle = 0;
    ipv4_fwd_pkg::data_t in_data_q [$];
    ipv4_fwd_pkg::keep_t in_keep_q [$];
    logic                in_last_q [$];
    longint              in_cyc_q  [$];
    logic                exp_err_q [$];
    ipv4_fwd_pkg::data_t out_data_q [$];
    ipv4_fwd_pkg::keep_t out_keep_q [$];
    longint              out_cyc_q  [$];

    // Folded ones' complement sum of the ten IPv4 header words
    function automatic int header_sum(input logic [7:0] b [256]);
        int sum;
        sum = 0;
        for (int i = 14; i < 34; i += 2) begin
            sum += int'({b[i], b[i+1]});
        end
        while (sum > 'hffff) begin
            sum = (sum & 'hffff) + (sum >> 16);
        end
        return sum;
    endfunction

    task automatic check_frame(input logic hdr_err);
        ipv4_fwd_pkg::data_t exp_d [32];
        ipv4_fwd_pkg::keep_t exp_k [32];
        longint              exp_c [32];
        logic [7:0]          b [256];
        logic                done;
        logic                err_flag;
        int                  n;
        int                  sum;
        n = 0;
        done = 1'b0;
        while (!done && n < 32 && in_data_q.size() > 0) begin
            exp_d[n] = in_data_q.pop_front();
            exp_k[n] = in_keep_q.pop_front();
            exp_c[n] = in_cyc_q.pop_front() + latency;
            done = in_last_q.pop_front();
            n++;
        end
        err_flag = (exp_err_q.size() > 0) ? exp_err_q.pop_front() : 1'b0;
        if (!done || n != out_data_q.size()) begin
            $display("ERROR %0t: frame %0d left with %0d beats, %0d went in",
                     $time, frames_done, out_data_q.size(), n);
            error_count++;
        end else begin
            for (int i = 0; i < 8 * n; i++) begin
                b[i] = exp_d[i/8][63-8*(i%8) -: 8];
            end
            sum = header_sum(b);
            // Forwarded frame gets TTL minus one and a checksum over the new header
            if ({b[12], b[13]} == ipv4_fwd_pkg::ipv4_ether_type && b[14] == 8'h45 &&
                sum == 'hffff && b[22] > 8'd1) begin
                b[22] = b[22] - 8'd1;
                b[24] = 8'h00;
                b[25] = 8'h00;
                sum = header_sum(b);
                {b[24], b[25]} = ~sum[15:0];
            end
            for (int i = 0; i < n; i++) begin
                for (int j = 0; j < 8; j++) begin
                    exp_d[i][63-8*j -: 8] = b[8*i+j];
                end
                if (out_data_q[i] !== exp_d[i] || out_keep_q[i] !== exp_k[i]) begin
                    $display("ERROR %0t: frame %0d beat %0d got %h/%h, expected %h/%h",
                             $time, frames_done, i, out_data_q[i], out_keep_q[i],
                             exp_d[i], exp_k[i]);
                    error_count++;
                end
                if (out_cyc_q[i] != exp_c[i]) begin
                    $display("ERROR %0t: frame %0d beat %0d left at cycle %0d, expected %0d",
                             $time, frames_done, i, out_cyc_q[i], exp_c[i]);
                    error_count++;
                end
            end
            if (hdr_err !== err_flag) begin
                $display("ERROR %0t: frame %0d out_hdr_err %b, expected %b",
                         $time, frames_done, hdr_err, err_flag);
                error_count++;
            end
        end
        frames_done++;
        out_data_q.delete();
        out_keep_q.delete();
        out_cyc_q.delete();
    endtask

    // Inputs are driven after the rising edge, so the falling edge sees settled values
    always @(negedge core_clk_ifc) begin
        cycle++;
        if (rst_n && in_valid) begin
            in_data_q.push_back(in_data);
            in_keep_q.push_back(in_keep);
            in_last_q.push_back(in_last);
            in_cyc_q.push_back(cycle);
            if (in_last) begin
                exp_err_q.push_back(exp_err);
            end
        end
        if (rst_n && out_valid) begin
            out_data_q.push_back(out_data);
            out_keep_q.push_back(out_keep);
            out_cyc_q.push_back(cycle);
            if (out_last) begin
                check_frame(out_hdr_err);
            end
        end
    end

endmodule

// File: testbench/ipv4_forwarder_tb.sv
/* IPv4 forwarder testbench */

`timescale 1ns/1ps

module ipv4_forwarder_tb;

    typedef struct packed {
        logic [7:0]  len;
        logic [7:0]  ttl;
        logic [15:0] ether_type;
        logic        bad_chk;
        logic [3:0]  gap;
        logic        exp_err;
    } frame_row_t;

    localparam int n_rows = 10;

    // Length, TTL, Ethernet type, corrupt checksum, idle gap, expected error flag
    frame_row_t rows [n_rows] = '{
        '{8'd64,  8'd64,  16'h0800, 1'b0, 4'd2, 1'b0},
        '{8'd71,  8'd64,  16'h0800, 1'b0, 4'd3, 1'b0},
        '{8'd64,  8'd1,   16'h0800, 1'b0, 4'd1, 1'b1},
        '{8'd100, 8'd64,  16'h0800, 1'b1, 4'd2, 1'b1},
        '{8'd64,  8'd64,  16'h86dd, 1'b0, 4'd0, 1'b1},
        '{8'd130, 8'd2,   16'h0800, 1'b0, 4'd0, 1'b0},
        '{8'd65,  8'd0,   16'h0800, 1'b0, 4'd0, 1'b1},
        '{8'd200, 8'd255, 16'h0800, 1'b0, 4'd4, 1'b0},
        '{8'd77,  8'd64,  16'h0800, 1'b1, 4'd0, 1'b1},
        '{8'd64,  8'd128, 16'h0800, 1'b0, 4'd3, 1'b0}
    };

    logic                core_clk_ifc;
    logic                rst_n;
    logic                in_valid;
    ipv4_fwd_pkg::data_t in_data;
    ipv4_fwd_pkg::keep_t in_keep;
    logic                in_last;
    logic                exp_err;
    logic                out_valid;
    ipv4_fwd_pkg::data_t out_data;
    ipv4_fwd_pkg::keep_t out_keep;
    logic                out_last;
    logic                out_hdr_err;
    logic [7:0]          frame [256];
    int                  timeouts;
    int                  wait_cycles;

    ipv4_forwarder UUT (.*);

    ipv4_forwarder_checker u_checker (.*);

    bind ipv4_forwarder ipv4_forwarder_props u_props (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .out_valid    (out_valid),
        .out_last     (out_last),
        .out_hdr_err  (out_hdr_err)
    );

    always #20 core_clk_ifc = ~core_clk_ifc;

    ////////////////////////////////////////
    // Frame build and drive

    task automatic build_frame(input frame_row_t row);
        int sum;
        for (int i = 0; i < 256; i++) begin
            frame[i] = 8'($urandom);
        end
        {frame[12], frame[13]} = row.ether_type;
        frame[14] = 8'h45;
        frame[15] = 8'h00;
        {frame[16], frame[17]} = 16'(row.len - 14);
        frame[22] = row.ttl;
        frame[23] = 8'h11;
        sum = 0;
        for (int i = 14; i < 34; i += 2) begin
            if (i != 24) begin
                sum += int'({frame[i], frame[i+1]});
            end
        end
        while (sum > 'hffff) begin
            sum = (sum & 'hffff) + (sum >> 16);
        end
        {frame[24], frame[25]} = ~sum[15:0] ^ (row.bad_chk ? 16'h0101 : 16'h0000);
    endtask

    // Beats back to back, then the idle gap
    task automatic send_frame(input frame_row_t row);
        int n_beats;
        n_beats = (int'(row.len) + 7) / 8;
        for (int k = 0; k < n_beats; k++) begin
            @(posedge core_clk_ifc);
            #1;
            in_valid = 1'b1;
            in_last  = (k == n_beats - 1);
            exp_err  = row.exp_err;
            for (int j = 0; j < 8; j++) begin
                in_data[63-8*j -: 8] = frame[8*k+j];
                in_keep[7-j]         = (8 * k + j < int'(row.len));
            end
        end
        for (int g = 0; g < int'(row.gap); g++) begin
            @(posedge core_clk_ifc);
            #1;
            in_valid = 1'b0;
            in_last  = 1'b0;
        end
    endtask

    ////////////////////////////////////////
    // Main sequence

    initial begin
        void'($urandom(32'hdae));
        core_clk_ifc = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_data      = '0;
        in_keep      = '0;
        in_last      = 1'b0;
        exp_err      = 1'b0;
        timeouts     = 0;
        repeat (10) @(posedge core_clk_ifc);
        #1;
        rst_n = 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            build_frame(rows[r]);
            send_frame(rows[r]);
        end
        wait_cycles = 0;
        while (u_checker.frames_done < n_rows && wait_cycles < 100) begin
            @(posedge core_clk_ifc);
            wait_cycles++;
        end
        if (u_checker.frames_done < n_rows) begin
            $display("Timed out waiting for output frames, %0d of %0d arrived",
                     u_checker.frames_done, n_rows);
            timeouts++;
        end
        $display("Error counts: checker %0d, assertion %0d, timeout %0d",
                 u_checker.error_count, UUT.u_props.fail_count, timeouts);
        if (u_checker.error_count == 0 && UUT.u_props.fail_count == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: tb.f
hw/ipv4_fwd_pkg.sv
hw/ipv4_fwd_ifcs.sv
hw/ipv4_hdr_decode.sv
hw/ipv4_ttl_execute.sv
hw/ipv4_result_stage.sv
hw/ipv4_forwarder.sv
testbench/ipv4_forwarder_props.sv
testbench/ipv4_forwarder_checker.sv
testbench/ipv4_forwarder_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the IPv4 forwarder testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module ipv4_forwarder_tb -o ipv4_forwarder_sim
./obj_dir/ipv4_forwarder_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
if grep -q "^Verification passed$" sim.log; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1
